// File: tb.f
+incdir+src
src/camera_phy_pkg.sv
src/lane_gearbox.sv
src/lane_aligner.sv
src/sync_decoder.sv
src/camera_phy_top.sv
tb/tb_clock_gen.sv
tb/camera_phy_tb.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run of the camera phy testbench
# the run log is searched for the fail line, any hit fails the script

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module camera_phy_tb \
  -f tb.f -Mdir obj_dir -o camera_phy_sim > build.log 2>&1 \
  || { cat build.log; echo "run_sim: build failed"; exit 1; }

./obj_dir/camera_phy_sim > sim.log 2>&1 \
  || { cat sim.log; echo "run_sim: simulator exited with an error"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "run_sim: failed"; exit 1; } || echo "run_sim: passed"

// File: tb/camera_phy_tb.sv
`timescale 1ns/1ps

`include "camera_phy_consts.svh"

// testbench for the hispi pixel side
// each lane is modelled as a serial bit stream, sliced into bytes for the DUT
module camera_phy_tb;

  import camera_phy_pkg::*;

  localparam int RESET_LIMIT = 20;    // cycles allowed for reset release
  localparam int DRAIN_LIMIT = 4000;  // cycles allowed to empty the reference

  logic        clk_out_pix;
  logic        idelay_rdy;
  logic        in_strobe;
  lane_bytes_t in_words;
  logic        pix_strobe;
  lane_pix_t   pix_data;
  logic        line_valid;
  sync_flags_t sync;
  logic [9:0]  sync_word;

  logic [31:0] lfsr;                          // fibonacci state
  logic        lane_bits [`CAM_LANES][$];     // serial stream, oldest bit first
  logic [9:0]  exp_pix   [`CAM_LANES][$];     // words that must come out with line_valid
  logic [9:0]  exp_code  [$];                 // code words in send order
  int          exp_len   [$];                 // pixels per reported line
  int          pix_rd;                        // monitor read pointers
  int          code_rd;
  int          len_rd;
  int          line_pix;                      // pixels seen in the open line
  logic        line_open;
  int          ref_cnt;                       // bits held by the gearbox model
  logic [2:0]  strobe_ref;                    // completing strobes, delayed 3 cycles
  int          value_errs = 0;                // wrong output values
  int          proto_errs = 0;                // outputs at the wrong time
  int          run_errs   = 0;                // timeouts

  tb_clock_gen clk_gen (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy)
  );

  camera_phy_top UUT (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy),
    .in_strobe   (in_strobe),
    .in_words    (in_words),
    .pix_strobe  (pix_strobe),
    .pix_data    (pix_data),
    .line_valid  (line_valid),
    .sync        (sync),
    .sync_word   (sync_word)
  );

  // -------------------------------------------------------------------------
  // random source and stream builders
  // -------------------------------------------------------------------------

  // x^32 + x^22 + x^2 + x + 1, shifting toward the msb
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken, the first bit ends up on top
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic put_word(input int l, input logic [9:0] w);
    for (int b = `CAM_PIX_W - 1; b >= 0; b--) begin
      lane_bits[l].push_back(w[b]);  // msb goes out first
    end
  endtask

  task automatic put_all(input logic [9:0] w);
    for (int l = 0; l < `CAM_LANES; l++) begin
      put_word(l, w);
    end
  endtask

  // 0..9 random bits shift the word boundary, same count on every lane
  task automatic put_pad();
    logic [31:0] v;
    int          n;
    rand_bits(4, v);
    n = int'(v[3:0]) % 10;
    for (int l = 0; l < `CAM_LANES; l++) begin
      for (int i = 0; i < n; i++) begin
        rand_bits(1, v);
        lane_bits[l].push_back(v[0]);
      end
    end
  endtask

  task automatic put_sync(input logic [2:0] code);
    logic [9:0] w;
    w = {7'h7f, code};  // set top bit ends the zero run at exactly 20
    put_all(10'h3ff);
    put_all(10'h000);
    put_all(10'h000);
    put_all(w);
    exp_code.push_back(w);
  endtask

  // pixels keep bit 9 set, so no run of 20 zeros can form
  task automatic put_line(input logic report);
    logic [31:0] v;
    logic [9:0]  w;
    int          n;
    rand_bits(3, v);
    n = 4 + int'(v[2:0]);
    for (int i = 0; i < n; i++) begin
      for (int l = 0; l < `CAM_LANES; l++) begin
        rand_bits(9, v);
        w = {1'b1, v[8:0]};
        put_word(l, w);
        if (report)
          exp_pix[l].push_back(w);
      end
    end
    if (report)
      exp_len.push_back(n);
  endtask

  // -------------------------------------------------------------------------
  // driver
  // -------------------------------------------------------------------------

  // slice the streams into bytes, oldest bit in bit 7, random gaps
  task automatic drive_stream();
    lane_bytes_t set;
    logic [31:0] v;
    int          gap;
    while (lane_bits[0].size() > 0) begin
      for (int l = 0; l < `CAM_LANES; l++) begin
        for (int b = `CAM_IN_W - 1; b >= 0; b--) begin
          if (lane_bits[l].size() > 0)
            set.lane[l][b] = lane_bits[l].pop_front();
          else
            set.lane[l][b] = 1'b1;  // ones fill the last byte
        end
      end
      @(negedge clk_out_pix);
      in_strobe = 1'b1;
      in_words  = set;
      rand_bits(2, v);
      gap = v[1] ? 0 : int'(v[0]) + 1;  // half the strobes back to back
      repeat (gap) begin
        @(negedge clk_out_pix);
        in_strobe = 1'b0;
      end
    end
    @(negedge clk_out_pix);
    in_strobe = 1'b0;
  endtask

  function automatic logic ref_drained();
    return (pix_rd == exp_pix[0].size()) && (code_rd == exp_code.size()) &&
           (len_rd == exp_len.size());
  endfunction

  task automatic wait_reset();
    int n;
    n = 0;
    while (!idelay_rdy && n < RESET_LIMIT) begin
      @(negedge clk_out_pix);
      n++;
    end
    assert (idelay_rdy) else begin
      run_errs++;
      $display("reset was never released");
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (!ref_drained() && n < DRAIN_LIMIT) begin
      @(negedge clk_out_pix);
      n++;
    end
    assert (ref_drained()) else begin
      run_errs++;
      $display("timed out with %0d of %0d pixel sets and %0d of %0d code words seen",
               pix_rd, exp_pix[0].size(), code_rd, exp_code.size());
    end
  endtask

  // -------------------------------------------------------------------------
  // reference and monitor
  // -------------------------------------------------------------------------

  function automatic sync_flags_t flags_for_code(input logic [2:0] c);
    sync_flags_t f;
    f = '0;
    case (c)
      `CAM_CODE_SOF: f.sof = 1'b1;
      `CAM_CODE_SOL: f.sol = 1'b1;
      `CAM_CODE_EOL: f.eol = 1'b1;
      `CAM_CODE_EOF: f.eof = 1'b1;
      default:       f.error = 1'b1;  // anything else is a bad code
    endcase
    return f;
  endfunction

  // a strobe that brings the held count to 10 completes a word,
  // pix_strobe follows it by 3 cycles
  always @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      ref_cnt    <= 0;
      strobe_ref <= '0;
    end else begin
      strobe_ref <= {strobe_ref[1:0], in_strobe && (ref_cnt + `CAM_IN_W >= `CAM_PIX_W)};
      if (in_strobe)
        ref_cnt <= (ref_cnt + `CAM_IN_W >= `CAM_PIX_W) ? ref_cnt + `CAM_IN_W - `CAM_PIX_W
                                                        : ref_cnt + `CAM_IN_W;
    end
  end

  // outputs settle after the rising edge, sampled half a cycle later
  always @(negedge clk_out_pix) begin : monitor
    logic [9:0]  code;
    sync_flags_t want;
    int          want_len;
    if (!idelay_rdy) begin
      pix_rd    = 0;
      code_rd   = 0;
      len_rd    = 0;
      line_pix  = 0;
      line_open = 1'b0;
    end else begin
      assert (pix_strobe === strobe_ref[2]) else begin
        value_errs++;
        $display("ERROR t=%0t pix_strobe got %b expected %b", $time, pix_strobe, strobe_ref[2]);
      end
      assert ($onehot0(sync)) else begin
        proto_errs++;
        $display("t=%0t more than one sync flag raised in one cycle", $time);
      end
      if (line_valid) begin
        assert (line_open && pix_strobe) else begin
          proto_errs++;
          $display("t=%0t line_valid high outside an open line or without pix_strobe", $time);
        end
        assert (pix_rd < exp_pix[0].size()) else begin
          proto_errs++;
          $display("t=%0t more pixels reported valid than were sent", $time);
        end
        if (pix_rd < exp_pix[0].size()) begin
          for (int l = 0; l < `CAM_LANES; l++) begin
            assert (pix_data.lane[l] === exp_pix[l][pix_rd]) else begin
              value_errs++;
              $display("ERROR t=%0t pix_data.lane[%0d] got %h expected %h",
                       $time, l, pix_data.lane[l], exp_pix[l][pix_rd]);
            end
          end
          pix_rd++;
        end
        line_pix++;
      end
      if (sync !== '0) begin
        assert (code_rd < exp_code.size()) else begin
          proto_errs++;
          $display("t=%0t sync flag raised with no sync sequence pending", $time);
        end
        if (code_rd < exp_code.size()) begin
          code = exp_code[code_rd];
          want = flags_for_code(code[2:0]);
          code_rd++;
          assert (sync === want) else begin
            value_errs++;
            $display("ERROR t=%0t sync got %b expected %b", $time, sync, want);
          end
          assert (sync_word === code) else begin
            value_errs++;
            $display("ERROR t=%0t sync_word got %h expected %h", $time, sync_word, code);
          end
        end
        if (sync.sof || sync.sol) begin
          line_open = 1'b1;  // pixels may follow
          line_pix  = 0;
        end else begin
          if (line_open) begin
            want_len = (len_rd < exp_len.size()) ? exp_len[len_rd] : -1;
            assert (line_pix == want_len) else begin
              value_errs++;
              $display("ERROR t=%0t line length got %0d expected %0d",
                       $time, line_pix, want_len);
            end
            len_rd++;
          end
          line_open = 1'b0;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // sequence
  // -------------------------------------------------------------------------

  initial begin : stimulus
    in_strobe = 1'b0;
    in_words  = '0;
    lfsr      = 32'hffe1_334b;
    // frame of four lines, a new bit offset before each opening sequence
    put_pad();
    put_sync(`CAM_CODE_SOF);
    put_line(1'b1);
    put_sync(`CAM_CODE_EOL);
    put_pad();
    put_sync(`CAM_CODE_SOL);
    put_line(1'b1);
    put_sync(`CAM_CODE_EOL);
    put_pad();
    put_sync(`CAM_CODE_SOL);
    put_line(1'b1);
    put_sync(3'b000);           // bad code closes the line
    put_line(1'b0);             // dropped, must not show as valid
    put_pad();
    put_sync(`CAM_CODE_SOL);
    put_line(1'b1);
    put_sync(`CAM_CODE_EOF);
    repeat (3) put_all(10'h3ff);  // idle words push the last code through
    wait_reset();
    if (run_errs == 0) begin
      repeat (4) @(negedge clk_out_pix);  // quiet window after reset
      drive_stream();
      wait_drained();
      repeat (20) @(negedge clk_out_pix);  // catch stray strobes or flags
    end
    $display("checked %0d pixel sets, %0d sync events; errors: %0d value, %0d protocol, %0d timeout",
             pix_rd, code_rd, value_errs, proto_errs, run_errs);
    if (value_errs + proto_errs + run_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

// free running pixel clock and the power-up reset for the testbench
module tb_clock_gen #(
  parameter real PERIOD_NS    = 100.0,  // 10 MHz pixel clock
  parameter int  RESET_CYCLES = 2
) (
  output logic clk_out_pix,
  output logic idelay_rdy    // active low reset, released on a falling edge
);

  // clock starts low, first rising edge at half a period
  initial begin
    clk_out_pix = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_out_pix = ~clk_out_pix;
  end

  initial begin
    idelay_rdy = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_out_pix);
    idelay_rdy = 1'b1;  // half a period clear of the next rising edge
  end

endmodule

// File: src/camera_phy_top.sv
`timescale 1ns/1ps

// hispi packetized-sp pixel side, four lanes of 10-bit pixels
// gearbox -> aligner -> decoder, one clock
module camera_phy_top (
  input  logic                        clk_out_pix,
  input  logic                        idelay_rdy,   // async, active low
  input  logic                        in_strobe,
  input  camera_phy_pkg::lane_bytes_t in_words,
  output logic                        pix_strobe,
  output camera_phy_pkg::lane_pix_t   pix_data,
  output logic                        line_valid,
  output camera_phy_pkg::sync_flags_t sync,
  output logic [9:0]                  sync_word
);

  import camera_phy_pkg::*;

  // ---------------------------------------------------------------------------
  // internal links
  // ---------------------------------------------------------------------------

  logic      word_strobe;  // gearbox word ready
  lane_pix_t words;        // raw 10-bit words, unaligned
  logic      step;         // aligner output ready
  lane_pix_t aligned;      // words at the recovered phase
  logic      sync_seen;

  // ---------------------------------------------------------------------------
  // pipeline
  // ---------------------------------------------------------------------------

  lane_gearbox u_gearbox (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy),
    .in_strobe   (in_strobe),
    .in_words    (in_words),
    .word_strobe (word_strobe),
    .words       (words)
  );

  lane_aligner u_aligner (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy),
    .word_strobe (word_strobe),
    .words       (words),
    .step        (step),
    .aligned     (aligned),
    .sync_seen   (sync_seen)
  );

  sync_decoder u_decoder (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy),
    .step        (step),
    .aligned     (aligned),
    .sync_seen   (sync_seen),
    .pix_strobe  (pix_strobe),
    .pix_data    (pix_data),
    .line_valid  (line_valid),
    .sync        (sync),
    .sync_word   (sync_word)
  );

endmodule

// File: src/sync_decoder.sv
`timescale 1ns/1ps

`include "camera_phy_consts.svh"

// sync code classification and pixel output stage
module sync_decoder (
  input  logic                        clk_out_pix,
  input  logic                        idelay_rdy,
  input  logic                        step,        // one aligned word set per pulse
  input  camera_phy_pkg::lane_pix_t   aligned,
  input  logic                        sync_seen,   // aligned lane 0 is a code word
  output logic                        pix_strobe,
  output camera_phy_pkg::lane_pix_t   pix_data,
  output logic                        line_valid,
  output camera_phy_pkg::sync_flags_t sync,
  output logic [9:0]                  sync_word    // last code word, debug
);

  import camera_phy_pkg::*;

  // pixel reaches the output three steps after it is aligned
  localparam int DLY = 3;

  logic [DLY:0] valid_pipe;      // one bit per word in flight
  lane_pix_t    dly [DLY];       // aligned words waiting for output
  logic         valid_in;        // value shifted into valid_pipe[0]
  sync_flags_t  flags;           // decode of this step

  // ---------------------------------------------------------------------------
  // code word classification
  // ---------------------------------------------------------------------------

  always_comb begin
    flags    = '0;
    valid_in = valid_pipe[0];  // hold line state between codes
    if (sync_seen) begin
      case (aligned.lane[0][2:0])
        `CAM_CODE_SOF: begin
          flags.sof = 1'b1;
          valid_in  = 1'b1;    // pixels follow
        end
        `CAM_CODE_SOL: begin
          flags.sol = 1'b1;
          valid_in  = 1'b1;
        end
        `CAM_CODE_EOF: begin
          flags.eof = 1'b1;
          valid_in  = 1'b0;
        end
        `CAM_CODE_EOL: begin
          flags.eol = 1'b1;
          valid_in  = 1'b0;
        end
        default: begin
          flags.error = 1'b1;  // unknown code closes the line
          valid_in    = 1'b0;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // output control
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      pix_strobe <= 1'b0;
      line_valid <= 1'b0;
      sync       <= '0;
      sync_word  <= '0;
      valid_pipe <= '0;
    end else begin
      pix_strobe <= step;
      line_valid <= 1'b0;
      sync       <= '0;
      if (step) begin
        // the preamble words still in flight are masked on the code step
        line_valid <= (&valid_pipe) & ~sync_seen;
        valid_pipe <= {valid_pipe[DLY-1:0], valid_in};
        sync       <= flags;
        if (sync_seen)
          sync_word <= aligned.lane[0];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // pixel delay line
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_out_pix) begin
    if (step) begin
      dly[0]   <= aligned;
      for (int i = 1; i < DLY; i++) begin
        dly[i] <= dly[i-1];
      end
      pix_data <= dly[DLY-1];  // oldest aligned slot
    end
  end

endmodule

// File: src/lane_aligner.sv
`timescale 1ns/1ps

`include "camera_phy_consts.svh"

// bit phase recovery from the lane-0 sync sequence
// the phase found on lane 0 is applied to every lane
module lane_aligner (
  input  logic                      clk_out_pix,
  input  logic                      idelay_rdy,
  input  logic                      word_strobe,
  input  camera_phy_pkg::lane_pix_t words,
  output logic                      step,       // word_strobe delayed one cycle
  output camera_phy_pkg::lane_pix_t aligned,    // newest word at the phase
  output logic                      sync_seen   // zeros just before the newest word
);

  import camera_phy_pkg::*;

  localparam int PH_W = $clog2(`CAM_PIX_W);

  logic [`CAM_LANES-1:0][`CAM_HIST_W-1:0] hist;       // newest word in the low bits
  logic [`CAM_LANES-1:0][`CAM_HIST_W-1:0] hist_next;  // history after this word
  logic [PH_W-1:0]                        phase;      // registered bit offset
  logic [PH_W-1:0]                        phase_next;
  logic                                   found;      // some offset holds 20 zeros
  logic [PH_W-1:0]                        found_ph;

  // ---------------------------------------------------------------------------
  // history shift and sync search
  // ---------------------------------------------------------------------------

  always_comb begin
    for (int l = 0; l < `CAM_LANES; l++) begin
      hist_next[l] = {hist[l][`CAM_HIST_W-`CAM_PIX_W-1:0], words.lane[l]};
    end
    // search the history as it stood before this word, high to low
    // so the lowest matching offset is the one left standing
    found    = 1'b0;
    found_ph = '0;
    for (int j = `CAM_PIX_W - 1; j >= 0; j--) begin
      if (hist[0][j +: `CAM_SYNC_ZEROS] == '0) begin
        found    = 1'b1;
        found_ph = PH_W'(j);
      end
    end
    // one load per sequence, a long zero run must not drag the phase
    phase_next = (found && !sync_seen) ? found_ph : phase;
  end

  // ---------------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      step      <= 1'b0;
      sync_seen <= 1'b0;
      phase     <= '0;
      hist      <= '1;  // all ones never looks like a sync run
    end else begin
      step <= word_strobe;
      if (word_strobe) begin
        hist      <= hist_next;
        phase     <= phase_next;
        sync_seen <= found & ~sync_seen;
      end
    end
  end

  // newest word at the new phase, msb oldest
  always_ff @(posedge clk_out_pix) begin
    if (word_strobe) begin
      for (int l = 0; l < `CAM_LANES; l++) begin
        aligned.lane[l] <= hist_next[l][phase_next +: `CAM_PIX_W];
      end
    end
  end

endmodule

// File: src/lane_gearbox.sv
`timescale 1ns/1ps

`include "camera_phy_consts.svh"

// 8-to-10 repacking for all lanes
// every lane sees the same strobe, so one bit count serves them all
module lane_gearbox (
  input  logic                        clk_out_pix,
  input  logic                        idelay_rdy,   // async, active low
  input  logic                        in_strobe,    // one cycle per byte set
  input  camera_phy_pkg::lane_bytes_t in_words,
  output logic                        word_strobe,  // one cycle per word set
  output camera_phy_pkg::lane_pix_t   words
);

  import camera_phy_pkg::*;

  // worst case held bits: 9 left over plus a fresh byte
  localparam int ACC_W = `CAM_PIX_W + `CAM_IN_W - 1;
  localparam int CNT_W = $clog2(ACC_W + 1);

  // ---------------------------------------------------------------------------
  // accumulator state
  // ---------------------------------------------------------------------------

  logic [CNT_W-1:0]                 bit_cnt;  // valid bits held, 0..9 between strobes
  logic [CNT_W-1:0]                 cnt_sum;  // count once the new byte is in
  logic                             emit;     // 10 or more bits after append
  logic [`CAM_LANES-1:0][ACC_W-1:0] acc;      // valid bits right aligned
  logic [`CAM_LANES-1:0][ACC_W-1:0] acc_sum;  // acc with the new byte appended

  // append the byte below the held bits, oldest stays on top
  always_comb begin
    cnt_sum = bit_cnt + CNT_W'(`CAM_IN_W);
    emit    = (cnt_sum >= CNT_W'(`CAM_PIX_W));
    for (int l = 0; l < `CAM_LANES; l++) begin
      acc_sum[l] = {acc[l][ACC_W-`CAM_IN_W-1:0], in_words.lane[l]};
    end
  end

  // ---------------------------------------------------------------------------
  // control, shared by all lanes
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      bit_cnt     <= '0;
      word_strobe <= 1'b0;
    end else begin
      word_strobe <= in_strobe & emit;  // word lands one cycle after its last byte
      if (in_strobe) begin
        if (emit)
          bit_cnt <= cnt_sum - CNT_W'(`CAM_PIX_W);  // oldest 10 leave
        else
          bit_cnt <= cnt_sum;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // per-lane data path
  // ---------------------------------------------------------------------------

  // bits above bit_cnt are stale, they are never selected
  always_ff @(posedge clk_out_pix) begin
    if (in_strobe) begin
      acc <= acc_sum;
      if (emit) begin
        for (int l = 0; l < `CAM_LANES; l++) begin
          // oldest 10 held bits sit just under the count
          words.lane[l] <= acc_sum[l][(cnt_sum - CNT_W'(`CAM_PIX_W)) +: `CAM_PIX_W];
        end
      end
    end
  end

endmodule

// File: src/camera_phy_pkg.sv
`include "camera_phy_consts.svh"

package camera_phy_pkg;

  // ---------------------------------------------------------------------------
  // lane bundles, lane 0 always in the low bits
  // ---------------------------------------------------------------------------

  // one deserialized byte per lane, oldest serial bit in bit 7
  typedef struct packed {
    logic [`CAM_LANES-1:0][`CAM_IN_W-1:0] lane;
  } lane_bytes_t;

  // one 10-bit word per lane, msb is the oldest bit
  typedef struct packed {
    logic [`CAM_LANES-1:0][`CAM_PIX_W-1:0] lane;
  } lane_pix_t;

  // ---------------------------------------------------------------------------
  // sync decode results
  // ---------------------------------------------------------------------------

  // single-cycle flags, one step wide
  typedef struct packed {
    logic sof;    // start of frame
    logic sol;    // start of line
    logic eol;    // end of line
    logic eof;    // end of frame
    logic error;  // code word not recognized
  } sync_flags_t;

endpackage

// File: src/camera_phy_consts.svh
`ifndef CAMERA_PHY_CONSTS_SVH
`define CAMERA_PHY_CONSTS_SVH

// ---------------------------------------------------------------------------
// lane geometry
// ---------------------------------------------------------------------------

`define CAM_LANES      4   // hispi data lanes
`define CAM_IN_W       8   // deserialized word per lane per strobe
`define CAM_PIX_W      10  // packetized-sp pixel width

// per-lane history, five pixel words deep
// (four aligned slots plus up to nine bits of phase slack)
`define CAM_HIST_W     50

// a sync sequence carries two all-zero words back to back
`define CAM_SYNC_ZEROS 20

// ---------------------------------------------------------------------------
// sync code words, low 3 bits of the fourth word of the sequence
// ---------------------------------------------------------------------------

`define CAM_CODE_SOF   3'b011  // start of frame
`define CAM_CODE_SOL   3'b001  // start of line
`define CAM_CODE_EOF   3'b111  // end of frame
`define CAM_CODE_EOL   3'b101  // end of line

`endif
